//--- debug_geom_pkg.sv
package debug_geom_pkg;

    localparam int WORD_W         = 32;               // pc, data memory and register words
    localparam int BYTE_W         = 8;                // uart byte
    localparam int BYTES_PER_WORD = WORD_W / BYTE_W;  // bytes sent per word

    localparam int IM_ADDR_W = 8;   // instruction memory is byte addressed
    localparam int DM_ADDR_W = 5;   // data memory word address
    localparam int RB_ADDR_W = 5;   // register number

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [BYTE_W-1:0]    byte_t;
    typedef logic [IM_ADDR_W-1:0] im_addr_t;
    typedef logic [DM_ADDR_W-1:0] dm_addr_t;
    typedef logic [RB_ADDR_W-1:0] rb_addr_t;

endpackage

//--- debug_cmd_pkg.sv
package debug_cmd_pkg;

    // host command bytes
    localparam debug_geom_pkg::byte_t CMD_WRITE_IM     = 8'h77;  // 'w'
    localparam debug_geom_pkg::byte_t CMD_SEND_INFO    = 8'h69;  // 'i'
    localparam debug_geom_pkg::byte_t CMD_STEP_BY_STEP = 8'h73;  // 's'
    localparam debug_geom_pkg::byte_t CMD_CONTINUE     = 8'h63;  // 'c'
    localparam debug_geom_pkg::byte_t CMD_STEP         = 8'h6e;  // 'n'

    typedef enum logic [2:0] {
        IDLE,
        LOAD_IM,
        READY,
        RUN,
        STEP_MODE,
        DUMP
    } ctrl_state_t;

endpackage

//--- debug_cmd_ctrl.sv
`timescale 1ns/10ps

module debug_cmd_ctrl #(
    parameter int IM_LOAD_BYTES = 255
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_rx_done,
    input  debug_geom_pkg::byte_t    i_rx_data,
    input  logic                     i_halt,
    input  logic                     i_dump_done,
    output logic                     o_im_wr_en,
    output debug_geom_pkg::im_addr_t o_im_addr,
    output debug_geom_pkg::byte_t    o_im_data,
    output logic                     o_pipeline_enable,
    output logic                     o_dump_start
);

    localparam debug_geom_pkg::im_addr_t LAST_ADDR =
        debug_geom_pkg::im_addr_t'(IM_LOAD_BYTES - 1);

    debug_cmd_pkg::ctrl_state_t state;
    debug_cmd_pkg::ctrl_state_t ret_state;   // where a finished dump goes back to
    debug_geom_pkg::im_addr_t   load_cnt;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state             <= debug_cmd_pkg::IDLE;
            ret_state         <= debug_cmd_pkg::IDLE;
            load_cnt          <= '0;
            o_im_wr_en        <= 1'b0;
            o_pipeline_enable <= 1'b0;
            o_dump_start      <= 1'b0;
        end else begin
            o_im_wr_en   <= 1'b0;
            o_dump_start <= 1'b0;
            case (state)
                debug_cmd_pkg::IDLE: begin
                    if (i_rx_done && i_rx_data == debug_cmd_pkg::CMD_WRITE_IM) begin
                        load_cnt <= '0;
                        state    <= debug_cmd_pkg::LOAD_IM;
                    end else if (i_rx_done && i_rx_data == debug_cmd_pkg::CMD_SEND_INFO) begin
                        ret_state    <= debug_cmd_pkg::IDLE;
                        o_dump_start <= 1'b1;
                        state        <= debug_cmd_pkg::DUMP;
                    end
                end
                debug_cmd_pkg::LOAD_IM: begin
                    if (i_rx_done) begin
                        o_im_wr_en <= 1'b1;
                        load_cnt   <= load_cnt + 1'b1;
                        if (load_cnt == LAST_ADDR) begin
                            state <= debug_cmd_pkg::READY;
                        end
                    end
                end
                debug_cmd_pkg::READY: begin
                    if (i_rx_done && i_rx_data == debug_cmd_pkg::CMD_CONTINUE) begin
                        o_pipeline_enable <= 1'b1;
                        state             <= debug_cmd_pkg::RUN;
                    end else if (i_rx_done && i_rx_data == debug_cmd_pkg::CMD_STEP_BY_STEP) begin
                        state <= debug_cmd_pkg::STEP_MODE;
                    end
                end
                debug_cmd_pkg::RUN: begin
                    if (i_halt) begin
                        o_pipeline_enable <= 1'b0;
                        ret_state         <= debug_cmd_pkg::IDLE;
                        o_dump_start      <= 1'b1;
                        state             <= debug_cmd_pkg::DUMP;
                    end
                end
                debug_cmd_pkg::STEP_MODE: begin
                    if (i_rx_done && i_rx_data == debug_cmd_pkg::CMD_STEP) begin
                        o_pipeline_enable <= 1'b1;        // one clock of execution
                        ret_state         <= debug_cmd_pkg::STEP_MODE;
                        state             <= debug_cmd_pkg::DUMP;
                    end else if (i_rx_done && i_rx_data == debug_cmd_pkg::CMD_CONTINUE) begin
                        o_pipeline_enable <= 1'b1;
                        state             <= debug_cmd_pkg::RUN;
                    end
                end
                debug_cmd_pkg::DUMP: begin
                    if (o_pipeline_enable) begin
                        // the step clock is over so the pc holds the new value
                        o_pipeline_enable <= 1'b0;
                        o_dump_start      <= 1'b1;
                    end else if (i_dump_done) begin
                        state <= ret_state;
                    end
                end
                default: state <= debug_cmd_pkg::IDLE;
            endcase
        end
    end

    // write address and data are registered with the write enable
    always_ff @(posedge i_clock) begin
        if (state == debug_cmd_pkg::LOAD_IM && i_rx_done) begin
            o_im_addr <= load_cnt;
            o_im_data <= i_rx_data;
        end
    end

endmodule

//--- dump_sequencer.sv
`timescale 1ns/10ps

module dump_sequencer #(
    parameter int DM_DEPTH = 32,
    parameter int RB_DEPTH = 32
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  debug_geom_pkg::word_t    i_pc_value,
    input  debug_geom_pkg::word_t    i_dm_data,
    input  debug_geom_pkg::word_t    i_rb_data,
    input  logic                     i_full,
    input  logic                     i_tx_busy,
    input  logic                     i_fifo_empty,
    output logic                     o_push,
    output debug_geom_pkg::word_t    o_push_word,
    output logic                     o_dm_rd_en,
    output debug_geom_pkg::dm_addr_t o_dm_addr,
    output logic                     o_rb_rd_en,
    output debug_geom_pkg::rb_addr_t o_rb_addr,
    output logic                     o_done
);

    localparam debug_geom_pkg::dm_addr_t DM_LAST = debug_geom_pkg::dm_addr_t'(DM_DEPTH - 1);
    localparam debug_geom_pkg::rb_addr_t RB_LAST = debug_geom_pkg::rb_addr_t'(RB_DEPTH - 1);

    typedef enum logic [2:0] {SQ_IDLE, SQ_READ, SQ_LATCH, SQ_PUSH, SQ_DRAIN} seq_state_t;
    typedef enum logic [1:0] {PH_PC, PH_DM, PH_RB} phase_t;

    seq_state_t               state;
    phase_t                   phase;
    debug_geom_pkg::dm_addr_t idx;    // word index within the current phase
    debug_geom_pkg::word_t    word;

    assign o_dm_rd_en  = (state == SQ_READ) && (phase == PH_DM);
    assign o_rb_rd_en  = (state == SQ_READ) && (phase == PH_RB);
    assign o_dm_addr   = idx;
    assign o_rb_addr   = debug_geom_pkg::rb_addr_t'(idx);
    assign o_push      = (state == SQ_PUSH) && !i_full;
    assign o_push_word = word;
    assign o_done      = (state == SQ_DRAIN) && i_fifo_empty && !i_tx_busy;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= SQ_IDLE;
            phase <= PH_PC;
            idx   <= '0;
        end else begin
            case (state)
                SQ_IDLE: begin
                    if (i_start) begin
                        phase <= PH_PC;
                        state <= SQ_PUSH;
                    end
                end
                SQ_READ:  state <= SQ_LATCH;   // memory answers next cycle
                SQ_LATCH: state <= SQ_PUSH;
                SQ_PUSH: begin
                    if (!i_full) begin
                        state <= SQ_READ;
                        case (phase)
                            PH_PC: begin
                                phase <= PH_DM;
                                idx   <= '0;
                            end
                            PH_DM: begin
                                idx <= idx + 1'b1;
                                if (idx == DM_LAST) begin
                                    phase <= PH_RB;
                                    idx   <= '0;
                                end
                            end
                            default: begin
                                idx <= idx + 1'b1;
                                if (debug_geom_pkg::rb_addr_t'(idx) == RB_LAST) begin
                                    state <= SQ_DRAIN;
                                end
                            end
                        endcase
                    end
                end
                SQ_DRAIN: begin
                    if (o_done) begin
                        state <= SQ_IDLE;
                    end
                end
                default: state <= SQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == SQ_IDLE && i_start) begin
            word <= i_pc_value;
        end else if (state == SQ_LATCH) begin
            word <= (phase == PH_DM) ? i_dm_data : i_rb_data;
        end
    end

endmodule

//--- word_fifo.sv
`timescale 1ns/10ps

module word_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_push,
    input  debug_geom_pkg::word_t i_push_word,
    input  logic                  i_pop,
    output debug_geom_pkg::word_t o_pop_word,
    output logic                  o_full,
    output logic                  o_empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    debug_geom_pkg::word_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  wr;
    logic                  rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr         = i_push && !o_full;
    assign rd         = i_pop && !o_empty;
    assign o_full     = (count == CNT_W'(FIFO_DEPTH));
    assign o_empty    = (count == '0);
    assign o_pop_word = mem[rd_ptr];   // head word visible before pop

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (wr && !rd) begin
                count <= count + 1'b1;
            end else if (rd && !wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (wr) begin
            mem[wr_ptr] <= i_push_word;
        end
    end

endmodule

//--- tx_byte_serializer.sv
`timescale 1ns/10ps

module tx_byte_serializer (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_empty,
    input  debug_geom_pkg::word_t i_pop_word,
    input  logic                  i_tx_done,
    output logic                  o_pop,
    output logic                  o_tx_start,
    output debug_geom_pkg::byte_t o_tx_data,
    output logic                  o_busy
);

    localparam int IDX_W = $clog2(debug_geom_pkg::BYTES_PER_WORD);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(debug_geom_pkg::BYTES_PER_WORD - 1);

    debug_geom_pkg::word_t word;
    logic [IDX_W-1:0]      byte_idx;   // 0 is the most significant byte
    logic                  have_word;
    logic                  send;

    assign o_pop  = !have_word && !i_empty;
    assign o_busy = have_word;
    assign send   = have_word && !o_tx_start;   // start is low at least one cycle

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            have_word  <= 1'b0;
            byte_idx   <= '0;
            o_tx_start <= 1'b0;
        end else if (o_pop) begin
            have_word <= 1'b1;
            byte_idx  <= '0;
        end else if (send) begin
            o_tx_start <= 1'b1;
        end else if (o_tx_start && i_tx_done) begin
            o_tx_start <= 1'b0;
            byte_idx   <= byte_idx + 1'b1;
            if (byte_idx == LAST_IDX) begin
                have_word <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_pop) begin
            word <= i_pop_word;
        end
        if (send) begin
            o_tx_data <= word[debug_geom_pkg::WORD_W - 1 - byte_idx * debug_geom_pkg::BYTE_W
                              -: debug_geom_pkg::BYTE_W];
        end
    end

endmodule

//--- debug_unit.sv
`timescale 1ns/10ps

module debug_unit #(
    parameter int DM_DEPTH      = 32,
    parameter int RB_DEPTH      = 32,
    parameter int IM_LOAD_BYTES = 255,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_rx_done,
    input  debug_geom_pkg::byte_t    i_rx_data,
    input  logic                     i_tx_done,
    input  logic                     i_halt,
    input  debug_geom_pkg::word_t    i_pc_value,
    input  debug_geom_pkg::word_t    i_dm_data,
    input  debug_geom_pkg::word_t    i_rb_data,
    output logic                     o_tx_start,
    output debug_geom_pkg::byte_t    o_tx_data,
    output logic                     o_im_wr_en,
    output debug_geom_pkg::im_addr_t o_im_addr,
    output debug_geom_pkg::byte_t    o_im_data,
    output logic                     o_dm_rd_en,
    output debug_geom_pkg::dm_addr_t o_dm_addr,
    output logic                     o_rb_rd_en,
    output debug_geom_pkg::rb_addr_t o_rb_addr,
    output logic                     o_pipeline_enable
);

    logic                  dump_start;
    logic                  dump_done;
    logic                  fifo_push;
    debug_geom_pkg::word_t push_word;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  fifo_pop;
    debug_geom_pkg::word_t pop_word;
    logic                  tx_busy;

    debug_cmd_ctrl #(
        .IM_LOAD_BYTES (IM_LOAD_BYTES)
    ) u_cmd_ctrl (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .i_halt            (i_halt),
        .i_dump_done       (dump_done),
        .o_im_wr_en        (o_im_wr_en),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_pipeline_enable (o_pipeline_enable),
        .o_dump_start      (dump_start)
    );

    dump_sequencer #(
        .DM_DEPTH (DM_DEPTH),
        .RB_DEPTH (RB_DEPTH)
    ) u_dump_seq (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_start      (dump_start),
        .i_pc_value   (i_pc_value),
        .i_dm_data    (i_dm_data),
        .i_rb_data    (i_rb_data),
        .i_full       (fifo_full),
        .i_tx_busy    (tx_busy),
        .i_fifo_empty (fifo_empty),
        .o_push       (fifo_push),
        .o_push_word  (push_word),
        .o_dm_rd_en   (o_dm_rd_en),
        .o_dm_addr    (o_dm_addr),
        .o_rb_rd_en   (o_rb_rd_en),
        .o_rb_addr    (o_rb_addr),
        .o_done       (dump_done)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_word_fifo (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_push      (fifo_push),
        .i_push_word (push_word),
        .i_pop       (fifo_pop),
        .o_pop_word  (pop_word),
        .o_full      (fifo_full),
        .o_empty     (fifo_empty)
    );

    tx_byte_serializer u_tx_ser (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_empty    (fifo_empty),
        .i_pop_word (pop_word),
        .i_tx_done  (i_tx_done),
        .o_pop      (fifo_pop),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .o_busy     (tx_busy)
    );

endmodule

//--- tb_debug_unit.sv
`timescale 1ns/10ps

module tb_debug_unit;

    localparam int DM_DEPTH      = 4;
    localparam int RB_DEPTH      = 4;
    localparam int IM_LOAD_BYTES = 8;
    localparam int FIFO_DEPTH    = 4;
    localparam int DATA_WORDS    = 64;
    localparam int DM_BASE       = IM_LOAD_BYTES;          // testdata layout
    localparam int RB_BASE       = DM_BASE + DM_DEPTH;
    localparam int RUN_IDX       = RB_BASE + RB_DEPTH;
    localparam int CMD_BASE      = RUN_IDX + 1;
    localparam int BYTE_TIMEOUT  = 400;                    // cycles allowed per uart byte
    localparam logic [31:0] SLOW_UART = 32'hff;            // list marker, never sent

    logic                     i_clock    = 1'b0;
    logic                     i_reset    = 1'b1;
    logic                     i_rx_done  = 1'b0;
    debug_geom_pkg::byte_t    i_rx_data  = '0;
    logic                     i_tx_done  = 1'b0;
    logic                     i_halt     = 1'b0;
    debug_geom_pkg::word_t    i_pc_value = '0;
    debug_geom_pkg::word_t    i_dm_data  = '0;
    debug_geom_pkg::word_t    i_rb_data  = '0;
    logic                     o_tx_start;
    debug_geom_pkg::byte_t    o_tx_data;
    logic                     o_im_wr_en;
    debug_geom_pkg::im_addr_t o_im_addr;
    debug_geom_pkg::byte_t    o_im_data;
    logic                     o_dm_rd_en;
    debug_geom_pkg::dm_addr_t o_dm_addr;
    logic                     o_rb_rd_en;
    debug_geom_pkg::rb_addr_t o_rb_addr;
    logic                     o_pipeline_enable;

    logic [31:0]                tdata [DATA_WORDS];
    debug_geom_pkg::byte_t      tx_bytes [$];          // bytes seen on the uart
    int                         cycles    = 0;         // enabled pipeline cycles
    int                         im_writes = 0;
    logic                       en_seen   = 1'b0;
    logic                       dm_rd_seen = 1'b0;
    logic                       rb_rd_seen = 1'b0;
    debug_geom_pkg::dm_addr_t   dm_addr_seen = '0;
    debug_geom_pkg::rb_addr_t   rb_addr_seen = '0;
    logic                       slow_uart = 1'b0;
    logic [7:0]                 lfsr      = 8'd51;
    debug_cmd_pkg::ctrl_state_t model_state;
    debug_geom_pkg::word_t      exp_pc;

    always #20 i_clock = ~i_clock;

    debug_unit #(
        .DM_DEPTH      (DM_DEPTH),
        .RB_DEPTH      (RB_DEPTH),
        .IM_LOAD_BYTES (IM_LOAD_BYTES),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_dut (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .i_tx_done         (i_tx_done),
        .i_halt            (i_halt),
        .i_pc_value        (i_pc_value),
        .i_dm_data         (i_dm_data),
        .i_rb_data         (i_rb_data),
        .o_tx_start        (o_tx_start),
        .o_tx_data         (o_tx_data),
        .o_im_wr_en        (o_im_wr_en),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_dm_rd_en        (o_dm_rd_en),
        .o_dm_addr         (o_dm_addr),
        .o_rb_rd_en        (o_rb_rd_en),
        .o_rb_addr         (o_rb_addr),
        .o_pipeline_enable (o_pipeline_enable)
    );

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "testbench stopped");
    endtask

    task automatic value_error(input string msg);
        fail_plain($sformatf("ERR %0t: %s", $time, msg));
    endtask

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    task automatic next_delay(output int d);
        d = 8;
        if (!slow_uart) begin
            d = 1;
            for (int i = 0; i < 3; i++) begin
                d = d + (int'(lfsr[0]) << i);
                lfsr = lfsr_step(lfsr);
            end
        end
    endtask

    // outputs are sampled mid cycle
    always @(negedge i_clock) begin
        en_seen      = o_pipeline_enable;
        dm_rd_seen   = o_dm_rd_en;
        dm_addr_seen = o_dm_addr;
        rb_rd_seen   = o_rb_rd_en;
        rb_addr_seen = o_rb_addr;
        if (o_im_wr_en) begin
            im_writes++;
        end
    end

    // core and memories answer 2 ns after the edge
    always @(posedge i_clock) begin
        #2;
        if (en_seen) begin
            cycles++;
        end
        i_pc_value = debug_geom_pkg::word_t'(4 * cycles);
        i_halt     = (cycles >= int'(tdata[RUN_IDX]) - 1);   // halting instr still in flight
        if (dm_rd_seen) begin
            i_dm_data = tdata[DM_BASE + int'(dm_addr_seen)];
        end
        if (rb_rd_seen) begin
            i_rb_data = tdata[RB_BASE + int'(rb_addr_seen)];
        end
    end

    always begin
        int delay;
        @(negedge i_clock);
        if (o_tx_start) begin
            tx_bytes.push_back(o_tx_data);
            next_delay(delay);
            repeat (delay) @(posedge i_clock);
            #2 i_tx_done = 1'b1;
            @(posedge i_clock);
            #2 i_tx_done = 1'b0;
            @(negedge i_clock);
            if (o_tx_start) begin
                fail_plain("tx_start stayed high into the next byte with no low cycle");
            end
        end
    end

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_error($sformatf("%s is %b, expected %b", name, got, exp));
        end
    endtask

    task automatic check_im_write(input debug_geom_pkg::im_addr_t exp_addr,
                                  input debug_geom_pkg::byte_t exp_data);
        if (o_im_wr_en !== 1'b1 || o_im_addr !== exp_addr || o_im_data !== exp_data) begin
            value_error($sformatf("im write en %b addr %02h data %02h, expected %02h %02h",
                                  o_im_wr_en, o_im_addr, o_im_data, exp_addr, exp_data));
        end
    endtask

    task automatic get_tx_byte(output debug_geom_pkg::byte_t b);
        int waited = 0;
        while (tx_bytes.size() == 0) begin
            if (waited == BYTE_TIMEOUT) begin
                fail_plain("timeout: the debug unit sent no uart byte");
            end
            waited++;
            @(posedge i_clock);
        end
        b = tx_bytes.pop_front();
    endtask

    task automatic check_byte(input debug_geom_pkg::byte_t exp);
        debug_geom_pkg::byte_t got;
        get_tx_byte(got);
        if (got !== exp) begin
            value_error($sformatf("uart byte %02h, expected %02h", got, exp));
        end
    endtask

    task automatic check_pc(input debug_geom_pkg::word_t exp);
        debug_geom_pkg::word_t got = '0;
        debug_geom_pkg::byte_t b;
        for (int k = 0; k < debug_geom_pkg::BYTES_PER_WORD; k++) begin
            get_tx_byte(b);
            got = (got << debug_geom_pkg::BYTE_W) | debug_geom_pkg::word_t'(b);
        end
        if (got !== exp) begin
            value_error($sformatf("dumped pc %08h, expected %08h", got, exp));
        end
    endtask

    task automatic expect_word(input debug_geom_pkg::word_t w);
        for (int k = debug_geom_pkg::BYTES_PER_WORD - 1; k >= 0; k--) begin
            check_byte(debug_geom_pkg::byte_t'(w >> (k * debug_geom_pkg::BYTE_W)));
        end
    endtask

    task automatic expect_dump(input debug_geom_pkg::word_t pc);
        check_pc(pc);
        for (int a = 0; a < DM_DEPTH; a++) begin
            expect_word(tdata[DM_BASE + a]);
        end
        for (int r = 0; r < RB_DEPTH; r++) begin
            expect_word(tdata[RB_BASE + r]);
        end
        repeat (20) @(posedge i_clock);
        if (tx_bytes.size() != 0) begin
            value_error("uart bytes beyond the end of the dump");
        end
    endtask

    task automatic expect_quiet(input int writes_before, input int cycles_before);
        repeat (20) @(posedge i_clock);
        if (tx_bytes.size() != 0 || im_writes != writes_before || cycles != cycles_before) begin
            value_error("a command without effect in this state caused activity");
        end
    endtask

    // ends at the falling edge after the DUT has seen rx_done
    task automatic send_byte(input debug_geom_pkg::byte_t b);
        @(posedge i_clock);
        #2;
        i_rx_data = b;
        i_rx_done = 1'b1;
        @(posedge i_clock);
        #2;
        i_rx_done = 1'b0;
        @(negedge i_clock);
    endtask

    task automatic load_program(input int writes_before);
        for (int i = 0; i < IM_LOAD_BYTES; i++) begin
            send_byte(debug_geom_pkg::byte_t'(tdata[i]));
            check_im_write(debug_geom_pkg::im_addr_t'(i), debug_geom_pkg::byte_t'(tdata[i]));
        end
        repeat (4) @(posedge i_clock);
        if (im_writes != writes_before + IM_LOAD_BYTES) begin
            value_error($sformatf("%0d im writes, expected %0d",
                                  im_writes - writes_before, IM_LOAD_BYTES));
        end
    endtask

    task automatic run_command(input debug_geom_pkg::byte_t cmd);
        int writes_before = im_writes;
        int cycles_before = cycles;
        send_byte(cmd);
        case (model_state)
            debug_cmd_pkg::IDLE: begin
                if (cmd == debug_cmd_pkg::CMD_WRITE_IM) begin
                    load_program(writes_before);
                    model_state = debug_cmd_pkg::READY;
                end else if (cmd == debug_cmd_pkg::CMD_SEND_INFO) begin
                    expect_dump(exp_pc);
                end else begin
                    expect_quiet(writes_before, cycles_before);
                end
            end
            debug_cmd_pkg::READY: begin
                if (cmd == debug_cmd_pkg::CMD_CONTINUE) begin
                    check_level("pipeline enable", o_pipeline_enable, 1'b1);
                    exp_pc = debug_geom_pkg::word_t'(4 * tdata[RUN_IDX]);
                    expect_dump(exp_pc);
                    model_state = debug_cmd_pkg::IDLE;   // run dumps go back to idle
                end else begin
                    if (cmd == debug_cmd_pkg::CMD_STEP_BY_STEP) begin
                        model_state = debug_cmd_pkg::STEP_MODE;
                    end
                    expect_quiet(writes_before, cycles_before);
                end
            end
            debug_cmd_pkg::STEP_MODE: begin
                if (cmd == debug_cmd_pkg::CMD_STEP) begin
                    check_level("pipeline enable", o_pipeline_enable, 1'b1);
                    @(negedge i_clock);
                    check_level("pipeline enable", o_pipeline_enable, 1'b0);   // one clock only
                    exp_pc = exp_pc + 4;
                    expect_dump(exp_pc);
                end else begin
                    expect_quiet(writes_before, cycles_before);
                end
            end
            default: fail_plain("the command model reached a state it does not handle");
        endcase
    endtask

    initial begin
        $readmemh("debug_unit_testdata.txt", tdata);
        model_state = debug_cmd_pkg::IDLE;
        exp_pc      = '0;
        repeat (10) @(posedge i_clock);
        #2;
        i_reset = 1'b0;
        @(negedge i_clock);
        check_level("tx start", o_tx_start, 1'b0);
        check_level("im write enable", o_im_wr_en, 1'b0);
        check_level("dm read enable", o_dm_rd_en, 1'b0);
        check_level("rb read enable", o_rb_rd_en, 1'b0);
        check_level("pipeline enable", o_pipeline_enable, 1'b0);
        for (int n = CMD_BASE; n < DATA_WORDS && tdata[n] != 32'h0; n++) begin
            if (tdata[n] == SLOW_UART) begin
                slow_uart = 1'b1;
            end else begin
                run_command(debug_geom_pkg::byte_t'(tdata[n]));
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- debug_unit_testdata.txt
// @00 load bytes, @08 data memory words, @0c register words,
// @10 enabled cycles of the run, @11 command bytes up to 00 (ff = slowest uart from here on)
@00
13 93 11 81 33 b3 33 3f
@08
deadbeef 01234567 89abcdef 00000000
@0c
00000000 11223344 a5a55a5a ffffffff
@10
0000000c
@11
69  // info after reset, pc 0
63  // continue in idle, ignored
77  // write instruction memory
6e  // step in ready, ignored
63  // run until halt, pc 48
73  // step-by-step in idle, ignored
69  // info from idle, pc 48
77  // load again
73  // enter step mode
6e  // step, pc 52
ff  // slowest uart from here
6e  // step, pc 56
69  // info in step mode, ignored
6e  // step, pc 60
00  // end of list

//--- debug_unit.f
debug_geom_pkg.sv
debug_cmd_pkg.sv
debug_cmd_ctrl.sv
dump_sequencer.sv
word_fifo.sv
tx_byte_serializer.sv
debug_unit.sv
tb_debug_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_debug_unit
DUT_TOP   ?= debug_unit
FILELIST  ?= debug_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
